// ==== testbench/dsp_slice_vectors.txt ====
# name b2b mem0 mem1 aa ab ba bb c_sel s_aa s_ab s_ba s_bb x y z op result eqz over under
# Selects and op are decimal codes, words and result are hex, b2b=1 strobes with no idle gap
lane_u01 0 0000C0005 FFFFFFFFE 0 1 0 0 0 0 0 0 0 1 0 0 0 0000000000000F 0 0 0
lane_u23 0 0000C0005 FFFFFFFFE 2 3 0 0 0 0 0 0 0 1 0 0 0 00000FFFF40002 0 0 0
lane_u23_sb 0 0000C0005 FFFFFFFFE 2 3 0 0 0 0 0 1 1 1 0 0 0 00000FFFF40002 0 0 0
lane_s23a 0 0000C0005 FFFFFFFFE 2 3 0 0 0 1 0 0 0 1 0 0 0 00000000000002 0 0 0
lane_s02b 0 0000C0005 FFFFFFFFE 0 2 0 0 0 0 1 0 0 1 0 0 0 3FFFFFFFFFFFF6 0 0 0
lane_s33 0 0000C0005 FFFFFFFFE 3 3 0 0 0 1 1 0 0 1 0 0 0 00000000000001 0 0 0
lane_u02pb 0 0000C0005 FFFFFFFFE 0 0 0 2 0 0 0 0 0 0 1 0 0 0000000013FFF6 0 0 0
lane_s13pb 0 0000C0005 FFFFFFFFE 0 0 1 3 0 0 0 0 1 0 1 0 0 3FFFFFFFFFFFFD 0 0 0
lane_u11pb 0 0000C0005 FFFFFFFFE 0 0 1 1 0 0 0 0 0 0 1 0 0 00000000000009 0 0 0
src_sum_c 0 0000C0005 000000100 0 1 2 0 0 0 0 0 0 2 0 1 0 000000000C0514 0 0 0
src_sum_chi 0 0000C0005 000000100 0 1 2 0 1 0 0 0 0 2 0 2 0 0000000400050F 0 0 0
src_chi_neg 0 800000000 000000001 2 2 0 0 0 0 0 0 0 2 0 2 0 20000000000001 0 0 0
src_c_plus_c 0 0000C0005 FFFFFFFFF 0 0 0 0 1 0 0 0 0 3 2 1 0 00002FFFFFFFFD 0 0 0
acc_load 0 000040007 000000000 0 1 0 0 0 0 0 0 0 1 0 0 0 00000000000007 0 0 0
acc_y1 1 000040007 000000000 0 1 0 0 0 0 0 0 0 1 3 0 0 0000000000000E 0 0 0
acc_y2 1 000040007 000000000 0 1 0 0 0 0 0 0 0 1 3 0 0 00000000000015 0 0 0
acc_z1 1 000040007 000000000 0 1 0 0 0 0 0 0 0 1 0 3 0 0000000000001C 0 0 0
acc_sub 1 000040007 000000000 0 1 0 0 0 0 0 0 0 1 0 3 1 00000000000015 0 0 0
acc_neg 1 000040007 000000000 0 1 0 0 0 0 0 0 0 3 0 3 1 3FFFFFFFFC000E 0 0 0
acc_back 1 000040007 000000000 0 1 0 0 0 0 0 0 0 3 3 0 0 00000000000015 0 0 0
sub_eqz 0 000040007 000000007 0 1 0 0 1 0 0 0 0 1 0 1 1 00000000000000 1 0 0
sub_self 0 123456789 000000000 0 0 0 0 0 0 0 0 0 3 0 1 1 00000000000000 1 0 0
add_zero 0 123456789 000000000 0 0 0 0 0 0 0 0 0 0 0 0 0 00000000000000 1 0 0
add_over 0 7FFFFFFFF 000000000 0 0 0 0 0 0 0 0 0 3 0 2 0 200007FFFBFFFF 0 1 0
sub_under 0 800000000 000000000 0 0 0 0 0 0 0 0 0 3 0 2 1 1FFFF800000000 0 0 1
sub_edge 0 800000000 000000000 0 0 0 0 0 0 0 0 0 0 0 2 1 20000000000000 0 0 0
log_and 0 0000C0005 00000003C 0 1 0 0 1 0 0 0 0 1 0 1 2 0000000000000C 0 0 0
log_or 0 0000C0005 00000003C 0 1 0 0 1 0 0 0 0 1 0 1 3 0000000000003F 0 0 0
log_xor 0 0000C0005 00000003C 0 1 0 0 1 0 0 0 0 1 0 1 4 00000000000033 0 0 0
log_and_neg 0 0000C0005 FFFFFFFFE 3 0 0 0 0 1 0 0 0 1 0 1 2 000000000C0001 0 0 0
log_or_neg 0 0000C0005 FFFFFFFFE 3 0 0 0 0 1 0 0 0 1 0 1 3 3FFFFFFFFFFFFF 0 0 0
log_xor_neg 0 0000C0005 FFFFFFFFE 3 0 0 0 0 1 0 0 0 1 0 1 4 3FFFFFFFF3FFFE 0 0 0
log_xor_self 0 123456789 000000000 0 0 0 0 0 0 0 0 0 3 0 1 4 00000000000000 1 0 0

// ==== dsp_slice.f ====
source/dsp_slice_pkg.sv
source/slice_ifs.sv
source/operand_decode.sv
source/mult_execute.sv
source/alu_result.sv
source/dsp_slice_top.sv
testbench/tb_dsp_slice.sv

// ==== Bender.yml ====
package:
  name: dsp_slice

sources:
  - files:
      - source/dsp_slice_pkg.sv
      - source/slice_ifs.sv
      - source/operand_decode.sv
      - source/mult_execute.sv
      - source/alu_result.sv
      - source/dsp_slice_top.sv
  - target: test
    files:
      - testbench/tb_dsp_slice.sv

// ==== testbench/tb_dsp_slice.sv ====
`timescale 1ns/1ps

module tb_dsp_slice;
    import dsp_slice_pkg::*;

    logic              CLK0;
    logic              rst_n;
    logic              in_valid;
    logic [WORD_W-1:0] mem0;
    logic [WORD_W-1:0] mem1;
    lane_sel_e         aa_sel;
    lane_sel_e         ab_sel;
    lane_sel_e         ba_sel;
    lane_sel_e         bb_sel;
    logic              c_sel;
    logic              sign_aa;
    logic              sign_ab;
    logic              sign_ba;
    logic              sign_bb;
    x_src_e            x_sel;
    y_src_e            y_sel;
    z_src_e            z_sel;
    alu_op_e           opcode;
    logic              out_valid;
    logic [ACC_W-1:0]  result;
    logic [WORD_W-1:0] result_hi;
    logic              eqz;
    logic              over;
    logic              under;

    // One entry per vector line, all queues indexed alike
    string             names[$];
    int                v_b2b[$];
    logic [WORD_W-1:0] v_mem0[$];
    logic [WORD_W-1:0] v_mem1[$];
    int                v_aa[$];
    int                v_ab[$];
    int                v_ba[$];
    int                v_bb[$];
    int                v_csel[$];
    int                v_saa[$];
    int                v_sab[$];
    int                v_sba[$];
    int                v_sbb[$];
    int                v_x[$];
    int                v_y[$];
    int                v_z[$];
    int                v_op[$];
    logic [ACC_W-1:0]  v_res[$];
    int                v_eqz[$];
    int                v_over[$];
    int                v_under[$];

    // Operations in flight, oldest first
    int   pending[$];
    int   issue_cycle[$];
    int   cycle = 0;
    int   checked = 0;
    int   n_vec = 0;
    logic loaded = 1'b0;

    dsp_slice_top dsp_slice_top_inst (
        .CLK0      (CLK0),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .mem0      (mem0),
        .mem1      (mem1),
        .aa_sel    (aa_sel),
        .ab_sel    (ab_sel),
        .ba_sel    (ba_sel),
        .bb_sel    (bb_sel),
        .c_sel     (c_sel),
        .sign_aa   (sign_aa),
        .sign_ab   (sign_ab),
        .sign_ba   (sign_ba),
        .sign_bb   (sign_bb),
        .x_sel     (x_sel),
        .y_sel     (y_sel),
        .z_sel     (z_sel),
        .opcode    (opcode),
        .out_valid (out_valid),
        .result    (result),
        .result_hi (result_hi),
        .eqz       (eqz),
        .over      (over),
        .under     (under)
    );

    initial begin
        CLK0 = 1'b0;
        forever #50 CLK0 = ~CLK0;
    end

    always @(posedge CLK0) begin
        cycle <= cycle + 1;
    end

    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic load_vectors();
        int                fd;
        int                n;
        string             line;
        logic [8*24-1:0]   name_raw;
        int                f[17];
        logic [WORD_W-1:0] m0;
        logic [WORD_W-1:0] m1;
        logic [ACC_W-1:0]  res;
        fd = $fopen("testbench/dsp_slice_vectors.txt", "r");
        assert (fd != 0) else begin
            $display("Cannot open the vector file testbench/dsp_slice_vectors.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 2 && line.getc(0) != "#") begin
                n = $sscanf(line,
                    "%s %d %h %h %d %d %d %d %d %d %d %d %d %d %d %d %d %h %d %d %d",
                    name_raw, f[0], m0, m1, f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], res, f[14], f[15], f[16]);
                assert (n == 21) else begin
                    $display("Vector line %0d has %0d fields instead of 21", n_vec, n);
                    stop_with_failure();
                end
                names.push_back($sformatf("%0s", name_raw));
                v_b2b.push_back(f[0]);
                v_mem0.push_back(m0);
                v_mem1.push_back(m1);
                v_aa.push_back(f[1]);
                v_ab.push_back(f[2]);
                v_ba.push_back(f[3]);
                v_bb.push_back(f[4]);
                v_csel.push_back(f[5]);
                v_saa.push_back(f[6]);
                v_sab.push_back(f[7]);
                v_sba.push_back(f[8]);
                v_sbb.push_back(f[9]);
                v_x.push_back(f[10]);
                v_y.push_back(f[11]);
                v_z.push_back(f[12]);
                v_op.push_back(f[13]);
                v_res.push_back(res);
                v_eqz.push_back(f[14]);
                v_over.push_back(f[15]);
                v_under.push_back(f[16]);
                n_vec++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input int i);
        in_valid = 1'b1;
        mem0     = v_mem0[i];
        mem1     = v_mem1[i];
        aa_sel   = lane_sel_e'(v_aa[i]);
        ab_sel   = lane_sel_e'(v_ab[i]);
        ba_sel   = lane_sel_e'(v_ba[i]);
        bb_sel   = lane_sel_e'(v_bb[i]);
        c_sel    = (v_csel[i] != 0);
        sign_aa  = (v_saa[i] != 0);
        sign_ab  = (v_sab[i] != 0);
        sign_ba  = (v_sba[i] != 0);
        sign_bb  = (v_sbb[i] != 0);
        x_sel    = x_src_e'(v_x[i]);
        y_sel    = y_src_e'(v_y[i]);
        z_sel    = z_src_e'(v_z[i]);
        opcode   = alu_op_e'(v_op[i]);
        pending.push_back(i);
        // The strobe is taken at the next rising edge
        issue_cycle.push_back(cycle + 1);
    endtask

    task automatic check_output();
        int idx;
        int issued;
        assert (pending.size() > 0) else begin
            $display("out_valid went high at cycle %0d with no operation in flight", cycle);
            stop_with_failure();
        end
        idx    = pending.pop_front();
        issued = issue_cycle.pop_front();
        // The next rising edge is the one that samples out_valid
        check_value(names[idx], "latency", PIPE_LATENCY, cycle + 1 - issued);
        check_value(names[idx], "result", v_res[idx], result);
        check_value(names[idx], "result_hi", v_res[idx][ACC_W-1:C_SHIFT], result_hi);
        check_value(names[idx], "eqz", v_eqz[idx], eqz);
        check_value(names[idx], "over", v_over[idx], over);
        check_value(names[idx], "under", v_under[idx], under);
        checked++;
    endtask

    // Outputs settle after the rising edge, so they are sampled on the falling one
    always @(negedge CLK0) begin
        if (rst_n === 1'b1 && out_valid === 1'b1) begin
            check_output();
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (n_vec * 4 + 40) @(posedge CLK0);
        $display("Watchdog expired after %0d cycles", n_vec * 4 + 40);
        stop_with_failure();
    end

    initial begin : driver
        int gap;
        void'($urandom(66));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        mem0     = '0;
        mem1     = '0;
        aa_sel   = LANE_M0_LO;
        ab_sel   = LANE_M0_LO;
        ba_sel   = LANE_M0_LO;
        bb_sel   = LANE_M0_LO;
        c_sel    = 1'b0;
        sign_aa  = 1'b0;
        sign_ab  = 1'b0;
        sign_ba  = 1'b0;
        sign_bb  = 1'b0;
        x_sel    = X_ZERO;
        y_sel    = Y_ZERO;
        z_sel    = Z_ZERO;
        opcode   = OP_ADD;
        load_vectors();
        loaded = 1'b1;

        repeat (10) @(posedge CLK0);
        @(negedge CLK0);
        check_value("reset", "out_valid", 0, out_valid);
        check_value("reset", "result", 0, result);
        check_value("reset", "result_hi", 0, result_hi);
        check_value("reset", "eqz", 0, eqz);
        check_value("reset", "over", 0, over);
        check_value("reset", "under", 0, under);
        rst_n = 1'b1;

        for (int i = 0; i < n_vec; i++) begin
            if (v_b2b[i] == 0) begin
                gap = $urandom % 4;
                repeat (gap) begin
                    @(negedge CLK0);
                    in_valid = 1'b0;
                end
            end
            @(negedge CLK0);
            apply_vector(i);
        end
        @(negedge CLK0);
        in_valid = 1'b0;
        repeat (PIPE_LATENCY + 1) @(negedge CLK0);

        if (checked == n_vec) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Only %0d of %0d results arrived", checked, n_vec);
            stop_with_failure();
        end
    end

endmodule

// ==== source/dsp_slice_top.sv ====
`timescale 1ns/1ps

module dsp_slice_top (
    input  logic                             CLK0,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  logic [dsp_slice_pkg::WORD_W-1:0] mem0,
    input  logic [dsp_slice_pkg::WORD_W-1:0] mem1,
    input  dsp_slice_pkg::lane_sel_e         aa_sel,
    input  dsp_slice_pkg::lane_sel_e         ab_sel,
    input  dsp_slice_pkg::lane_sel_e         ba_sel,
    input  dsp_slice_pkg::lane_sel_e         bb_sel,
    input  logic                             c_sel,
    input  logic                             sign_aa,
    input  logic                             sign_ab,
    input  logic                             sign_ba,
    input  logic                             sign_bb,
    input  dsp_slice_pkg::x_src_e            x_sel,
    input  dsp_slice_pkg::y_src_e            y_sel,
    input  dsp_slice_pkg::z_src_e            z_sel,
    input  dsp_slice_pkg::alu_op_e           opcode,
    output logic                             out_valid,
    output logic [dsp_slice_pkg::ACC_W-1:0]  result,
    output logic [dsp_slice_pkg::WORD_W-1:0] result_hi,
    output logic                             eqz,
    output logic                             over,
    output logic                             under
);
    import dsp_slice_pkg::*;

    operand_if ops_if ();
    product_if prods_if ();

    operand_decode operand_decode_inst (
        .CLK0     (CLK0),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .mem0     (mem0),
        .mem1     (mem1),
        .aa_sel   (aa_sel),
        .ab_sel   (ab_sel),
        .ba_sel   (ba_sel),
        .bb_sel   (bb_sel),
        .c_sel    (c_sel),
        .sign_aa  (sign_aa),
        .sign_ab  (sign_ab),
        .sign_ba  (sign_ba),
        .sign_bb  (sign_bb),
        .x_sel    (x_sel),
        .y_sel    (y_sel),
        .z_sel    (z_sel),
        .opcode   (opcode),
        .ops      (ops_if.src)
    );

    mult_execute mult_execute_inst (
        .CLK0  (CLK0),
        .rst_n (rst_n),
        .ops   (ops_if.dst),
        .prods (prods_if.src)
    );

    alu_result alu_result_inst (
        .CLK0      (CLK0),
        .rst_n     (rst_n),
        .prods     (prods_if.dst),
        .out_valid (out_valid),
        .result    (result),
        .eqz       (eqz),
        .over      (over),
        .under     (under)
    );

    // Upper 36 bits of the ALU word, the part above the shifted C position
    assign result_hi = result[ACC_W-1:C_SHIFT];

endmodule

// ==== source/alu_result.sv ====
`timescale 1ns/1ps

module alu_result (
    input  logic                            CLK0,
    input  logic                            rst_n,
    product_if.dst                          prods,
    output logic                            out_valid,
    output logic [dsp_slice_pkg::ACC_W-1:0] result,
    output logic                            eqz,
    output logic                            over,
    output logic                            under
);
    import dsp_slice_pkg::*;

    // Three guard bits hold the exact sum of three 54-bit signed operands
    logic        [ACC_W-1:0] accum;
    logic signed [ACC_W+2:0] pa_w;
    logic signed [ACC_W+2:0] pb_w;
    logic signed [ACC_W+2:0] c_w;
    logic signed [ACC_W+2:0] c_high_w;
    logic signed [ACC_W+2:0] acc_w;
    logic signed [ACC_W+2:0] x_w;
    logic signed [ACC_W+2:0] y_w;
    logic signed [ACC_W+2:0] z_w;
    logic signed [ACC_W+2:0] sum_w;
    logic        [ACC_W-1:0] logic_res;
    logic        [ACC_W-1:0] alu_res;
    logic                    arith;
    logic                    alu_over;
    logic                    alu_under;

    assign pa_w  = {{3{prods.prod_a[ACC_W-1]}}, prods.prod_a};
    assign pb_w  = {{3{prods.prod_b[ACC_W-1]}}, prods.prod_b};
    assign acc_w = {{3{accum[ACC_W-1]}}, accum};
    assign c_w   = {{(ACC_W+3-WORD_W){1'b0}}, prods.c_word};

    // Shifted C fills the whole ALU word, so its top bit acts as the sign
    assign c_high_w = {{3{prods.c_word[WORD_W-1]}}, prods.c_word, {C_SHIFT{1'b0}}};

    always_comb begin
        case (prods.x_src)
            X_PROD_A:   x_w = pa_w;
            X_PROD_SUM: x_w = pa_w + pb_w;
            X_C:        x_w = c_w;
            default:    x_w = '0;
        endcase
        case (prods.y_src)
            Y_PROD_B: y_w = pb_w;
            Y_C:      y_w = c_w;
            Y_ACCUM:  y_w = acc_w;
            default:  y_w = '0;
        endcase
        case (prods.z_src)
            Z_C:      z_w = c_w;
            Z_C_HIGH: z_w = c_high_w;
            Z_ACCUM:  z_w = acc_w;
            default:  z_w = '0;
        endcase
    end

    always_comb begin
        sum_w     = '0;
        logic_res = '0;
        arith     = 1'b0;
        case (prods.op)
            OP_ADD: begin
                sum_w = x_w + y_w + z_w;
                arith = 1'b1;
            end
            OP_SUB: begin
                sum_w = z_w - (x_w + y_w);
                arith = 1'b1;
            end
            OP_AND:  logic_res = x_w[ACC_W-1:0] & z_w[ACC_W-1:0];
            OP_OR:   logic_res = x_w[ACC_W-1:0] | z_w[ACC_W-1:0];
            OP_XOR:  logic_res = x_w[ACC_W-1:0] ^ z_w[ACC_W-1:0];
            default: logic_res = '0;
        endcase
        alu_res = arith ? sum_w[ACC_W-1:0] : logic_res;
        // Out of range when the guard bits and bit 53 disagree with the true sign
        alu_over  = arith & ~sum_w[ACC_W+2] & (|sum_w[ACC_W+1:ACC_W-1]);
        alu_under = arith & sum_w[ACC_W+2] & ~(&sum_w[ACC_W+1:ACC_W-1]);
    end

    always_ff @(posedge CLK0) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            accum     <= '0;
            eqz       <= 1'b0;
            over      <= 1'b0;
            under     <= 1'b0;
        end else begin
            out_valid <= prods.valid;
            if (prods.valid) begin
                accum <= alu_res;
                eqz   <= (alu_res == '0);
                over  <= alu_over;
                under <= alu_under;
            end
        end
    end

    // The accumulator is the last result, held until the next one
    assign result = accum;

    a_flags_exclusive: assert property (
        @(posedge CLK0) disable iff (!rst_n)
        !(over && under)
    );

    a_logic_no_flags: assert property (
        @(posedge CLK0) disable iff (!rst_n)
        prods.valid && (prods.op inside {OP_AND, OP_OR, OP_XOR}) |=> !over && !under
    );

endmodule

// ==== source/mult_execute.sv ====
`timescale 1ns/1ps

module mult_execute (
    input  logic   CLK0,
    input  logic   rst_n,
    operand_if.dst ops,
    product_if.src prods
);
    import dsp_slice_pkg::*;

    logic [ACC_W-1:0] prod_a_ext;
    logic [ACC_W-1:0] prod_b_ext;

    // One 18x18 multiply, both operands taken as signed or both as unsigned,
    // then widened to the ALU width
    function automatic logic [ACC_W-1:0] mul_ext(
        input logic [LANE_W-1:0] a,
        input logic [LANE_W-1:0] b,
        input logic              sgn
    );
        logic signed [PROD_W-1:0] p_s;
        logic        [PROD_W-1:0] p_u;
        p_s = $signed(a) * $signed(b);
        p_u = a * b;
        if (sgn) begin
            return {{(ACC_W-PROD_W){p_s[PROD_W-1]}}, p_s};
        end
        return {{(ACC_W-PROD_W){1'b0}}, p_u};
    endfunction

    assign prod_a_ext = mul_ext(ops.a_lane, ops.b_lane, ops.signed_a);
    assign prod_b_ext = mul_ext(ops.c_lane, ops.d_lane, ops.signed_b);

    always_ff @(posedge CLK0) begin
        if (!rst_n) begin
            prods.valid <= 1'b0;
        end else begin
            prods.valid <= ops.valid;
        end
    end

    always_ff @(posedge CLK0) begin
        if (ops.valid) begin
            prods.prod_a <= prod_a_ext;
            prods.prod_b <= prod_b_ext;
            prods.c_word <= ops.c_word;
            prods.x_src  <= ops.x_src;
            prods.y_src  <= ops.y_src;
            prods.z_src  <= ops.z_src;
            prods.op     <= ops.op;
        end
    end

    a_valid_known: assert property (
        @(posedge CLK0) disable iff (!rst_n)
        !$isunknown(prods.valid)
    );

endmodule

// ==== source/operand_decode.sv ====
`timescale 1ns/1ps

module operand_decode (
    input  logic                             CLK0,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  logic [dsp_slice_pkg::WORD_W-1:0] mem0,
    input  logic [dsp_slice_pkg::WORD_W-1:0] mem1,
    input  dsp_slice_pkg::lane_sel_e         aa_sel,
    input  dsp_slice_pkg::lane_sel_e         ab_sel,
    input  dsp_slice_pkg::lane_sel_e         ba_sel,
    input  dsp_slice_pkg::lane_sel_e         bb_sel,
    input  logic                             c_sel,
    input  logic                             sign_aa,
    input  logic                             sign_ab,
    input  logic                             sign_ba,
    input  logic                             sign_bb,
    input  dsp_slice_pkg::x_src_e            x_sel,
    input  dsp_slice_pkg::y_src_e            y_sel,
    input  dsp_slice_pkg::z_src_e            z_sel,
    input  dsp_slice_pkg::alu_op_e           opcode,
    operand_if.src                           ops
);
    import dsp_slice_pkg::*;

    logic [LANE_W-1:0] lanes [4];
    logic [WORD_W-1:0] c_pick;

    // Lane order follows the lane_sel_e encoding
    assign lanes[0] = mem0[LANE_W-1:0];
    assign lanes[1] = mem0[WORD_W-1:LANE_W];
    assign lanes[2] = mem1[LANE_W-1:0];
    assign lanes[3] = mem1[WORD_W-1:LANE_W];

    assign c_pick = c_sel ? mem1 : mem0;

    always_ff @(posedge CLK0) begin
        if (!rst_n) begin
            ops.valid <= 1'b0;
        end else begin
            ops.valid <= in_valid;
        end
    end

    always_ff @(posedge CLK0) begin
        if (in_valid) begin
            ops.a_lane   <= lanes[aa_sel];
            ops.b_lane   <= lanes[ab_sel];
            ops.c_lane   <= lanes[ba_sel];
            ops.d_lane   <= lanes[bb_sel];
            // A product is signed as soon as one of its operands is
            ops.signed_a <= sign_aa | sign_ab;
            ops.signed_b <= sign_ba | sign_bb;
            ops.c_word   <= c_pick;
            ops.x_src    <= x_sel;
            ops.y_src    <= y_sel;
            ops.z_src    <= z_sel;
            ops.op       <= opcode;
        end
    end

    a_legal_opcode: assert property (
        @(posedge CLK0) disable iff (!rst_n)
        in_valid |-> opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR}
    );

endmodule

// ==== source/slice_ifs.sv ====
`timescale 1ns/1ps

// Decoded operands and ALU controls, from the decode stage to the multipliers
interface operand_if;
    import dsp_slice_pkg::*;

    logic              valid;
    logic [LANE_W-1:0] a_lane;
    logic [LANE_W-1:0] b_lane;
    logic [LANE_W-1:0] c_lane;
    logic [LANE_W-1:0] d_lane;
    logic              signed_a;
    logic              signed_b;
    logic [WORD_W-1:0] c_word;
    x_src_e            x_src;
    y_src_e            y_src;
    z_src_e            z_src;
    alu_op_e           op;

    modport src (
        output valid, a_lane, b_lane, c_lane, d_lane, signed_a, signed_b,
        output c_word, x_src, y_src, z_src, op
    );

    modport dst (
        input valid, a_lane, b_lane, c_lane, d_lane, signed_a, signed_b,
        input c_word, x_src, y_src, z_src, op
    );
endinterface

// Extended products with the delayed C word, from the multipliers to the ALU
interface product_if;
    import dsp_slice_pkg::*;

    logic             valid;
    logic [ACC_W-1:0] prod_a;
    logic [ACC_W-1:0] prod_b;
    logic [WORD_W-1:0] c_word;
    x_src_e           x_src;
    y_src_e           y_src;
    z_src_e           z_src;
    alu_op_e          op;

    modport src (output valid, prod_a, prod_b, c_word, x_src, y_src, z_src, op);

    modport dst (input valid, prod_a, prod_b, c_word, x_src, y_src, z_src, op);
endinterface

// ==== source/dsp_slice_pkg.sv ====
package dsp_slice_pkg;

    // Multiplier operand lane width
    localparam int LANE_W = 18;

    // Memory word and C operand width
    localparam int WORD_W = 36;

    // Raw product width of one 18x18 multiply
    localparam int PROD_W = 36;

    // ALU and accumulator width
    localparam int ACC_W = 54;

    // Bit position of C when it is placed in the upper part of the ALU word
    localparam int C_SHIFT = 18;

    // Cycles from the input strobe to the registered result
    localparam int PIPE_LATENCY = 3;

    // Which 18-bit half of which memory word feeds a multiplier operand
    typedef enum logic [1:0] {
        LANE_M0_LO = 2'd0,
        LANE_M0_HI = 2'd1,
        LANE_M1_LO = 2'd2,
        LANE_M1_HI = 2'd3
    } lane_sel_e;

    typedef enum logic [1:0] {
        X_ZERO     = 2'd0,
        X_PROD_A   = 2'd1,
        X_PROD_SUM = 2'd2,
        X_C        = 2'd3
    } x_src_e;

    typedef enum logic [1:0] {
        Y_ZERO   = 2'd0,
        Y_PROD_B = 2'd1,
        Y_C      = 2'd2,
        Y_ACCUM  = 2'd3
    } y_src_e;

    typedef enum logic [1:0] {
        Z_ZERO   = 2'd0,
        Z_C      = 2'd1,
        Z_C_HIGH = 2'd2,
        Z_ACCUM  = 2'd3
    } z_src_e;

    // Codes 5 to 7 are illegal
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4
    } alu_op_e;

endpackage
